//--- sources.f
+incdir+bench
verilog/busTermPkg.sv
verilog/cycleDecode.sv
verilog/cycleHold.sv
verilog/transferAck.sv
verilog/busTermTop.sv
bench/busTermTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the bus termination testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module busTermTb \
    -Mdir obj_dir \
    -o busTermSim

# Simulator status is ignored here, the log decides
./obj_dir/busTermSim | tee sim.log

if grep -qx "All checks passed" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

//--- bench/busTermModel.svh
`ifndef BUSTERMMODEL_SVH
`define BUSTERMMODEL_SVH

////////////////////////////////////////////////////////////
// Reference classification
////////////////////////////////////////////////////////////

// Class a cycle should get from its address and transfer type
function automatic busTermPkg::cycleClass expectedClass(input logic [31:0] a,
                                                       input logic [1:0]  t);
    busTermPkg::cycleClass k;
    if (t == busTermPkg::TT_INTACK) begin
        // Interrupt ack is an autovector wherever it points
        k = busTermPkg::CYC_SHORT;
    end else if ((a & busTermPkg::ROM_MASK) == busTermPkg::ROM_BASE) begin
        k = busTermPkg::CYC_ROM;
    end else if ((a & busTermPkg::CIA_MASK) == busTermPkg::CIA_BASE) begin
        k = busTermPkg::CYC_CIA;
    end else if ((a & busTermPkg::CHIP_MASK) == busTermPkg::CHIP_BASE) begin
        k = busTermPkg::CYC_EXTERNAL;
    end else if ((a & busTermPkg::FAST_MASK) == busTermPkg::FAST_BASE) begin
        k = busTermPkg::CYC_EXTERNAL;
    end else begin
        // Unmapped
        k = busTermPkg::CYC_SHORT;
    end
    return k;
endfunction

////////////////////////////////////////////////////////////
// Expected output windows, n counts edges after the TS edge
////////////////////////////////////////////////////////////

// Ack edge known up front, -1 when it is not
function automatic int fixedAckEdge(input busTermPkg::cycleClass k);
    int edgeNum;
    case (k)
        busTermPkg::CYC_SHORT: edgeNum = 2;
        // Request edge, then ROM_WAIT counts, then the ack flop
        busTermPkg::CYC_ROM:   edgeNum = 2 + int'(busTermPkg::ROM_WAIT);
        default:               edgeNum = -1;
    endcase
    return edgeNum;
endfunction

// nTA low on the ack edge only
function automatic logic ackExpected(input busTermPkg::cycleClass k, input int n,
                                     input int ackAt);
    return k != busTermPkg::CYC_EXTERNAL && n == ackAt;
endfunction

// Drive enable from the open edge through the force-high cycle
function automatic logic driveWindow(input busTermPkg::cycleClass k, input int n,
                                     input int ackAt);
    return k != busTermPkg::CYC_EXTERNAL && n >= 1 && (ackAt < 0 || n <= ackAt + 1);
endfunction

// ROM enable up to and including the ack edge
function automatic logic romWindow(input busTermPkg::cycleClass k, input int n,
                                   input int ackAt);
    return k == busTermPkg::CYC_ROM && n >= 1 && n <= ackAt;
endfunction

// RAM cycles stay busy until the next TS
function automatic logic busyExpected(input busTermPkg::cycleClass k, input int n,
                                      input int ackAt);
    if (k == busTermPkg::CYC_EXTERNAL) begin
        return n >= 1;
    end
    return driveWindow(k, n, ackAt);
endfunction

`endif

//--- bench/busTermTb.sv
`default_nettype none
`timescale 1ns/1ps

module busTermTb;

    localparam int  NUM_DIRECTED  = 15;
    localparam int  NUM_RANDOM    = 48;
    localparam int  NUM_CYCLES    = NUM_DIRECTED + NUM_RANDOM + 1;
    localparam int  WATCHDOG_NS   = NUM_CYCLES * 400 + 2000;
    localparam time CIA_ACK_LIMIT = 160;

    // DUT inputs
    logic        CLK40;
    logic        nRESET;
    logic        TS;
    logic [31:0] addr;
    logic [1:0]  tt;
    logic        CLKCIA;

    // DUT outputs
    logic        nTA;
    logic        taDrive;
    logic        nTCI;
    logic        tciDrive;
    logic        nROMEN;
    logic        busy;

    integer      seed;
    int          valueErrors;
    int          otherErrors;

    // Compare process state for the cycle in flight
    logic                  active;
    logic                  tsAtEdge;
    logic [31:0]           edgeAddr;
    logic [1:0]            edgeTt;
    busTermPkg::cycleClass expKind;
    int                    cycleNum;
    logic [31:0]           cycAddr;
    logic [1:0]            cycTt;
    int                    n;
    int                    ackAt;
    int                    taLows;
    logic                  sawTaDrive;
    logic                  sawRomen;
    logic                  sawTci;
    logic                  sawCiaHigh;
    logic                  sawCiaFall;
    time                   fallTime;

    `include "busTermModel.svh"

    busTermTop u_busTermTop (
        .CLK40    (CLK40),
        .nRESET   (nRESET),
        .TS       (TS),
        .addr     (addr),
        .tt       (tt),
        .CLKCIA   (CLKCIA),
        .nTA      (nTA),
        .taDrive  (taDrive),
        .nTCI     (nTCI),
        .tciDrive (tciDrive),
        .nROMEN   (nROMEN),
        .busy     (busy)
    );

    ////////////////////////////////////////////////////////////
    // Clocks and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        CLK40 = 1'b0;
        forever #5 CLK40 = ~CLK40;
    end

    // Slow CIA clock, edges land 2 ns ahead of CLK40 rising edges
    initial begin
        CLKCIA = 1'b0;
        #3;
        forever begin
            CLKCIA = ~CLKCIA;
            #50;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("Error counts: value %0d, other %0d", valueErrors, otherErrors);
        $display("Checks failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Compare helpers
    ////////////////////////////////////////////////////////////

    task automatic checkBit(input string what, input logic got, input logic exp);
        assert (got === exp) else begin
            valueErrors++;
            $display("** Error at %0t: %s is %b, expected %b (cycle %0d, edge %0d)",
                     $time, what, got, exp, cycleNum, n);
        end
    endtask

    // Nothing driven, nothing selected
    task automatic checkIdle();
        checkBit("nTA", nTA, 1'b1);
        checkBit("taDrive", taDrive, 1'b0);
        checkBit("nTCI", nTCI, 1'b1);
        checkBit("tciDrive", tciDrive, 1'b0);
        checkBit("nROMEN", nROMEN, 1'b1);
        checkBit("busy", busy, 1'b0);
    endtask

    task automatic openCycle(input logic [31:0] a, input logic [1:0] t);
        cycleNum++;
        cycAddr    = a;
        cycTt      = t;
        expKind    = expectedClass(a, t);
        n          = 0;
        ackAt      = fixedAckEdge(expKind);
        taLows     = 0;
        sawTaDrive = 1'b0;
        sawRomen   = 1'b0;
        sawTci     = 1'b0;
        sawCiaHigh = 1'b0;
        sawCiaFall = 1'b0;
        fallTime   = 0;
        active     = 1'b1;
    endtask

    // Class as seen from the bus outputs alone
    function automatic busTermPkg::cycleClass observedClass();
        if (!sawTaDrive && taLows == 0) begin
            return busTermPkg::CYC_EXTERNAL;
        end else if (sawRomen) begin
            return busTermPkg::CYC_ROM;
        end else if (sawTci) begin
            return busTermPkg::CYC_CIA;
        end
        return busTermPkg::CYC_SHORT;
    endfunction

    task automatic closeCycle();
        busTermPkg::cycleClass obsKind;
        obsKind = observedClass();
        assert (obsKind == expKind) else begin
            valueErrors++;
            $display("** Error at %0t: cycle %0d (addr %h, tt %0d) ended as %s, expected %s",
                     $time, cycleNum, cycAddr, cycTt, obsKind.name(), expKind.name());
        end
        if (expKind != busTermPkg::CYC_EXTERNAL) begin
            assert (taLows == 1) else begin
                otherErrors++;
                $display("Cycle %0d at addr %h saw %0d acknowledges instead of one",
                         cycleNum, cycAddr, taLows);
            end
        end
        active = 1'b0;
    endtask

    task automatic checkSample();
        logic ackNow;
        logic inDrive;
        // CIA model follows CLKCIA from the request on
        if (expKind == busTermPkg::CYC_CIA && ackAt < 0) begin
            if (CLKCIA) begin
                sawCiaHigh = 1'b1;
            end else if (sawCiaHigh && !sawCiaFall) begin
                sawCiaFall = 1'b1;
                fallTime   = $time;
            end
            if (!nTA) begin
                ackAt = n;
                assert (sawCiaFall) else begin
                    otherErrors++;
                    $display("CIA cycle %0d acknowledged before CLKCIA went high then low",
                             cycleNum);
                end
                assert (!sawCiaFall || $time - fallTime <= CIA_ACK_LIMIT) else begin
                    valueErrors++;
                    $display("** Error at %0t: CIA ack %0t after the CLKCIA fall",
                             $time, $time - fallTime);
                end
            end
        end
        ackNow  = ackExpected(expKind, n, ackAt);
        inDrive = driveWindow(expKind, n, ackAt);
        checkBit("nTA", nTA, !ackNow);
        checkBit("taDrive", taDrive, inDrive);
        checkBit("nTCI", nTCI, !(ackNow && expKind == busTermPkg::CYC_CIA));
        checkBit("tciDrive", tciDrive, inDrive && expKind == busTermPkg::CYC_CIA);
        checkBit("nROMEN", nROMEN, !romWindow(expKind, n, ackAt));
        checkBit("busy", busy, busyExpected(expKind, n, ackAt));
        // Raw observations for the class guess
        if (!nTA) begin
            taLows++;
        end
        if (taDrive) begin
            sawTaDrive = 1'b1;
        end
        if (!nROMEN) begin
            sawRomen = 1'b1;
        end
        if (!nTCI) begin
            sawTci = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////////////////////////

    // TS taken at the edge, outputs read 1 ns after it
    always @(posedge CLK40) begin
        tsAtEdge = TS && nRESET;
        edgeAddr = addr;
        edgeTt   = tt;
        #1;
        if (tsAtEdge) begin
            // Only a RAM cycle may still be busy here
            if (!active || expKind != busTermPkg::CYC_EXTERNAL) begin
                checkIdle();
            end
            if (active) begin
                closeCycle();
            end
            openCycle(edgeAddr, edgeTt);
        end else if (active) begin
            n = n + 1;
            checkSample();
        end else begin
            checkIdle();
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // One TS pulse, then wait until the bus is free again
    task automatic runCycle(input logic [31:0] a, input logic [1:0] t);
        busTermPkg::cycleClass k;
        k = expectedClass(a, t);
        @(negedge CLK40);
        TS   = 1'b1;
        addr = a;
        tt   = t;
        @(negedge CLK40);
        TS   = 1'b0;
        addr = '0;
        tt   = '0;
        if (k == busTermPkg::CYC_EXTERNAL) begin
            // RAM controller would end it, the next TS stands in
            repeat (3) @(negedge CLK40);
        end else begin
            while (!busy) @(negedge CLK40);
            while (busy) @(negedge CLK40);
            @(negedge CLK40);
        end
    endtask

    task automatic randomCycle();
        logic [31:0] r;
        logic [31:0] pick;
        logic [31:0] a;
        logic [1:0]  t;
        r    = $random(seed);
        pick = $random(seed);
        // Mostly normal transfers, some interrupt acks
        t = pick[3] ? pick[1:0] : 2'd0;
        case (pick[10:8])
            3'd0:    a = (r & ~busTermPkg::ROM_MASK) | busTermPkg::ROM_BASE;
            3'd1:    a = (r & ~busTermPkg::CIA_MASK) | busTermPkg::CIA_BASE;
            3'd2:    a = (r & ~busTermPkg::CHIP_MASK) | busTermPkg::CHIP_BASE;
            3'd3:    a = (r & ~busTermPkg::FAST_MASK) | busTermPkg::FAST_BASE;
            default: a = r;
        endcase
        runCycle(a, t);
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        seed        = 32'h9b3b_1700;
        valueErrors = 0;
        otherErrors = 0;
        active      = 1'b0;
        cycleNum    = 0;
        n           = 0;
        expKind     = busTermPkg::CYC_SHORT;
        nRESET      = 1'b0;
        TS          = 1'b0;
        addr        = '0;
        tt          = '0;
        repeat (2) @(posedge CLK40);
        @(negedge CLK40);
        nRESET = 1'b1;
        // Idle bus after reset
        repeat (3) @(negedge CLK40);

        // Short cycles
        runCycle(32'h00F8_0000, busTermPkg::TT_INTACK);
        runCycle(32'h4000_0000, 2'd0);
        // ROM
        runCycle(32'h00F8_0000, 2'd0);
        runCycle(32'h00FF_FFFC, 2'd1);
        // CIA
        runCycle(32'h00BF_E001, 2'd0);
        runCycle(32'h00BF_D100, 2'd2);
        // RAM, then terminated cycles on top of it
        runCycle(32'h0000_1000, 2'd0);
        runCycle(32'h001F_FFFC, 2'd1);
        runCycle(32'h0800_0000, 2'd0);
        runCycle(32'h00FC_0000, 2'd0);
        runCycle(32'h0FFF_FFF0, 2'd0);
        runCycle(32'h00BF_E101, 2'd0);
        // Just outside the windows
        runCycle(32'h0020_0000, 2'd0);
        runCycle(32'h00BE_FFFF, 2'd0);
        runCycle(32'h1000_0000, 2'd0);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            randomCycle();
        end
        // Last cycle terminates so the bus ends idle
        runCycle(32'h7000_0000, 2'd2);

        repeat (2) @(negedge CLK40);
        closeCycle();
        repeat (3) @(negedge CLK40);
        $display("Error counts: value %0d, other %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/busTermTop.sv
`default_nettype none
`timescale 1ns/1ps

module busTermTop (
    input  wire         CLK40,
    input  wire         nRESET,
    input  wire         TS,
    input  wire  [31:0] addr,
    input  wire  [1:0]  tt,
    input  wire         CLKCIA,
    output logic        nTA,
    output logic        taDrive,
    output logic        nTCI,
    output logic        tciDrive,
    output logic        nROMEN,
    output logic        busy
);

    // Decoder to hold block
    logic                 cycleReq;
    busTermPkg::cycleInfo reqInfo;

    // Hold block to ack block
    logic                 cycleOpen;
    busTermPkg::cycleInfo curInfo;
    logic                 startPulse;
    logic                 tail;

    // Ack back to hold block
    logic                 ta;

    cycleDecode u_cycleDecode (
        .CLK40    (CLK40),
        .nRESET   (nRESET),
        .TS       (TS),
        .addr     (addr),
        .tt       (tt),
        .cycleReq (cycleReq),
        .reqInfo  (reqInfo)
    );

    cycleHold u_cycleHold (
        .CLK40      (CLK40),
        .nRESET     (nRESET),
        .cycleReq   (cycleReq),
        .reqInfo    (reqInfo),
        .ta         (ta),
        .cycleOpen  (cycleOpen),
        .curInfo    (curInfo),
        .startPulse (startPulse),
        .tail       (tail)
    );

    transferAck u_transferAck (
        .CLK40      (CLK40),
        .nRESET     (nRESET),
        .CLKCIA     (CLKCIA),
        .cycleOpen  (cycleOpen),
        .curInfo    (curInfo),
        .startPulse (startPulse),
        .tail       (tail),
        .ta         (ta),
        .nTA        (nTA),
        .taDrive    (taDrive),
        .nTCI       (nTCI),
        .tciDrive   (tciDrive),
        .nROMEN     (nROMEN),
        .busy       (busy)
    );

endmodule

`default_nettype wire

//--- verilog/transferAck.sv
`default_nettype none
`timescale 1ns/1ps

module transferAck (
    input  wire                   CLK40,
    input  wire                   nRESET,
    input  wire                   CLKCIA,
    input  wire                   cycleOpen,
    input  busTermPkg::cycleInfo  curInfo,
    input  wire                   startPulse,
    input  wire                   tail,
    output logic                  ta,
    output logic                  nTA,
    output logic                  taDrive,
    output logic                  nTCI,
    output logic                  tciDrive,
    output logic                  nROMEN,
    output logic                  busy
);

    logic [1:0] romCount;
    logic       romTa;
    logic       shortTa;
    logic [1:0] ciaSync;
    logic       ciaArmed;
    logic       ciaTa;
    logic       isRom;
    logic       isCia;
    logic       isShort;

    assign isRom   = curInfo.kind == busTermPkg::CYC_ROM;
    assign isCia   = curInfo.kind == busTermPkg::CYC_CIA;
    assign isShort = curInfo.kind == busTermPkg::CYC_SHORT;

    ////////////////////////////////////////////////////////////
    // ROM delay
    ////////////////////////////////////////////////////////////

    // Count off the ROM setup time, ack when it reaches ROM_WAIT
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            romCount <= 2'd0;
            romTa    <= 1'b0;
        end else begin
            romTa <= 1'b0;
            if (startPulse && isRom) begin
                romCount <= 2'd1;
            end else if (romCount == busTermPkg::ROM_WAIT) begin
                romTa    <= 1'b1;
                romCount <= 2'd0;
            end else if (romCount != 2'd0) begin
                romCount <= romCount + 2'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Short cycle
    ////////////////////////////////////////////////////////////

    // Autovector and unmapped end right after the start cycle
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            shortTa <= 1'b0;
        end else begin
            shortTa <= startPulse && isShort;
        end
    end

    ////////////////////////////////////////////////////////////
    // CIA ack
    ////////////////////////////////////////////////////////////

    // Ack only after a clean high then low of the CIA clock
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            ciaSync  <= 2'b00;
            ciaArmed <= 1'b0;
            ciaTa    <= 1'b0;
        end else begin
            // Two flops against metastability
            ciaSync <= {ciaSync[0], CLKCIA};
            ciaTa   <= 1'b0;
            if (!cycleOpen || !isCia) begin
                ciaArmed <= 1'b0;
            end else if (!ciaArmed && !ciaTa && !startPulse && ciaSync == 2'b11) begin
                // Samples now both postdate the request
                ciaArmed <= 1'b1;
            end else if (ciaArmed && ciaSync == 2'b00) begin
                ciaArmed <= 1'b0;
                ciaTa    <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Bus outputs
    ////////////////////////////////////////////////////////////

    // Only one timer runs per cycle
    assign ta = romTa || shortTa || ciaTa;

    // RAM cycles leave TA to the RAM controller
    assign taDrive  = (cycleOpen && curInfo.kind != busTermPkg::CYC_EXTERNAL) || tail;
    assign nTA      = ~ta;

    // Cache inhibit rides along with the CIA ack
    assign tciDrive = taDrive && curInfo.noCache;
    assign nTCI     = ~(ta && curInfo.noCache);

    assign nROMEN   = ~(cycleOpen && curInfo.romSelect);
    assign busy     = cycleOpen || tail;

    // Each ack lasts one clock, then the tail forces nTA high
    taPulse: assert property (@(posedge CLK40) disable iff (!nRESET)
        ta |=> !ta)
    else $error("transferAck: ta longer than one cycle");

endmodule

`default_nettype wire

//--- verilog/cycleHold.sv
`default_nettype none
`timescale 1ns/1ps

module cycleHold (
    input  wire                   CLK40,
    input  wire                   nRESET,
    input  wire                   cycleReq,
    input  busTermPkg::cycleInfo  reqInfo,
    input  wire                   ta,
    output logic                  cycleOpen,
    output busTermPkg::cycleInfo  curInfo,
    output logic                  startPulse,
    output logic                  tail
);

    typedef enum logic {
        HOLD_IDLE = 1'b0,
        HOLD_OPEN = 1'b1
    } holdState;

    holdState state;

    ////////////////////////////////////////////////////////////
    // Open cycle tracking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            state      <= HOLD_IDLE;
            startPulse <= 1'b0;
            tail       <= 1'b0;
        end else begin
            // New request also replaces an open RAM cycle
            if (cycleReq) begin
                state <= HOLD_OPEN;
            end else if (ta) begin
                state <= HOLD_IDLE;
            end
            startPulse <= cycleReq;
            // Force-high cycle for nTA after every ack
            tail       <= ta;
        end
    end

    // Info stays put after close so the tail cycle still sees it
    always_ff @(posedge CLK40) begin
        if (cycleReq) begin
            curInfo <= reqInfo;
        end
    end

    assign cycleOpen = state == HOLD_OPEN;

    ////////////////////////////////////////////////////////////
    // Bus protocol checks
    ////////////////////////////////////////////////////////////

    // CPU may only start a new cycle on top of a RAM cycle
    noOverlap: assert property (@(posedge CLK40) disable iff (!nRESET)
        cycleReq |-> (!cycleOpen || curInfo.kind == busTermPkg::CYC_EXTERNAL))
    else $error("cycleHold: TS while a terminated cycle is still open");

    // Ack from transferAck belongs to an open cycle
    taInCycle: assert property (@(posedge CLK40) disable iff (!nRESET)
        ta |-> cycleOpen)
    else $error("cycleHold: ta without an open cycle");

endmodule

`default_nettype wire

//--- verilog/cycleDecode.sv
`default_nettype none
`timescale 1ns/1ps

module cycleDecode (
    input  wire                   CLK40,
    input  wire                   nRESET,
    input  wire                   TS,
    input  wire  [31:0]           addr,
    input  wire  [1:0]            tt,
    output logic                  cycleReq,
    output busTermPkg::cycleInfo  reqInfo
);

    logic [31:0] addrReg;
    logic [1:0]  ttReg;
    logic        hitRom;
    logic        hitCia;
    logic        hitChip;
    logic        hitFast;
    logic        intAck;

    ////////////////////////////////////////////////////////////
    // Address capture
    ////////////////////////////////////////////////////////////

    // Address and TT are only valid with TS
    always_ff @(posedge CLK40) begin
        if (TS) begin
            addrReg <= addr;
            ttReg   <= tt;
        end
    end

    // One request per TS in the cycle after it
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            cycleReq <= 1'b0;
        end else begin
            cycleReq <= TS;
        end
    end

    ////////////////////////////////////////////////////////////
    // Classification
    ////////////////////////////////////////////////////////////

    assign hitRom  = (addrReg & busTermPkg::ROM_MASK) == busTermPkg::ROM_BASE;
    assign hitCia  = (addrReg & busTermPkg::CIA_MASK) == busTermPkg::CIA_BASE;
    assign hitChip = (addrReg & busTermPkg::CHIP_MASK) == busTermPkg::CHIP_BASE;
    assign hitFast = (addrReg & busTermPkg::FAST_MASK) == busTermPkg::FAST_BASE;
    assign intAck  = ttReg == busTermPkg::TT_INTACK;

    always_comb begin
        reqInfo.romSelect = 1'b0;
        reqInfo.noCache   = 1'b0;
        // Interrupt ack wins over any window since the CPU wants an autovector
        if (intAck) begin
            reqInfo.kind = busTermPkg::CYC_SHORT;
        end else if (hitRom) begin
            reqInfo.kind      = busTermPkg::CYC_ROM;
            reqInfo.romSelect = 1'b1;
        end else if (hitCia) begin
            reqInfo.kind    = busTermPkg::CYC_CIA;
            // CIA registers must never be cached
            reqInfo.noCache = 1'b1;
        end else if (hitChip || hitFast) begin
            // RAM controller ends these itself
            reqInfo.kind = busTermPkg::CYC_EXTERNAL;
        end else begin
            // Nothing answers here so end it quickly
            reqInfo.kind = busTermPkg::CYC_SHORT;
        end
    end

    // Class of a request comes from a fully known address and TT
    reqKindKnown: assert property (@(posedge CLK40) disable iff (!nRESET)
        cycleReq |-> !$isunknown({addrReg, ttReg}))
    else $error("cycleDecode: request classified from unknown address or TT");

endmodule

`default_nettype wire

//--- verilog/busTermPkg.sv
`default_nettype none

package busTermPkg;

    ////////////////////////////////////////////////////////////
    // Cycle classes
    ////////////////////////////////////////////////////////////

    // How the current bus cycle gets terminated
    typedef enum logic [1:0] {
        // RAM space, another device drives TA
        CYC_EXTERNAL = 2'd0,
        // Kickstart ROM, delayed ack
        CYC_ROM      = 2'd1,
        // CIA space, ack follows the E clock
        CYC_CIA      = 2'd2,
        // Autovector or unmapped, two clock cycle
        CYC_SHORT    = 2'd3
    } cycleClass;

    // Decoded cycle, handed from decoder to hold block to ack block
    typedef struct packed {
        cycleClass kind;
        logic      romSelect;
        logic      noCache;
    } cycleInfo;

    ////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////

    // A window matches when (addr & MASK) == BASE
    localparam logic [31:0] ROM_BASE  = 32'h00F8_0000;
    localparam logic [31:0] ROM_MASK  = 32'hFFF8_0000;
    localparam logic [31:0] CIA_BASE  = 32'h00BF_0000;
    localparam logic [31:0] CIA_MASK  = 32'hFFFF_0000;
    localparam logic [31:0] CHIP_BASE = 32'h0000_0000;
    localparam logic [31:0] CHIP_MASK = 32'hFFE0_0000;
    localparam logic [31:0] FAST_BASE = 32'h0800_0000;
    localparam logic [31:0] FAST_MASK = 32'hF800_0000;

    // TT encoding of an interrupt acknowledge
    localparam logic [1:0] TT_INTACK = 2'd3;

    // CLK40 cycles from request to ROM ack
    localparam logic [1:0] ROM_WAIT = 2'd3;

endpackage

`default_nettype wire
